// File: Makefile
# Verilator build and run for the FP32 unit testbench

TOP    ?= fpu_tb
LOG    ?= sim.log
OBJ    ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	verilator $(VFLAGS) -f sources.f --top-module $(TOP) --Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: common/fpu_macros.svh
//--------------------
// Port widths of the FP32 unit
//--------------------
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

`define FPU_DATA_WIDTH      32
`define FPU_NUM_OPERANDS    3
`define FPU_OP_WIDTH        6   // Vector, modifier, 4-bit operation
`define FPU_IN_FLAGS_WIDTH  15  // Reserved, int fmt, src fmt, dst fmt, rounding
`define FPU_OUT_FLAGS_WIDTH 5   // NV DZ OF UF NX

`endif

// File: common/fpu_pkg.sv
//--------------------
// Shared FP32 unit types: operations, rounding modes, operand classes
//--------------------
`default_nettype none

package fpu_pkg;

  // Operation field of the opcode word
  typedef enum logic [3:0] {
    FP_ADD    = 4'd2,  // Subtract when the modifier is set
    FP_MUL    = 4'd3,
    FP_SGNJ   = 4'd6,
    FP_MINMAX = 4'd7
  } fp_op_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } round_mode_e;

  typedef enum logic [2:0] {
    ZERO   = 3'd0,  // Also subnormals
    NORMAL = 3'd1,
    INF    = 3'd2,
    QNAN   = 3'd3,
    SNAN   = 3'd4
  } fp_class_e;

  parameter logic [31:0] CANON_NAN = 32'h7fc0_0000;

endpackage

`default_nettype wire

// File: dv/fpu_clk_gen.sv
//--------------------
// Testbench clock and reset
//--------------------
`default_nettype none

module fpu_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period
  end

  // Reset held for two rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/fpu_input.txt
// id op flags op0 op1 op2 result status (hex); id bits 15:8 = group
// flags[2:0] = rounding mode; status = NV DZ OF UF NX
0101 02 0000 00000000 3f800000 40000000 40400000 00
0102 12 0000 00000000 40400000 40400000 00000000 00
0103 12 0002 00000000 40400000 40400000 80000000 00
0104 02 0000 00000000 3f7fffff 33000000 3f800000 01
0105 02 0001 00000000 3f7fffff 33000000 3f7fffff 01
0106 02 0000 00000000 7f7fffff 7f7fffff 7f800000 05
0107 02 0001 00000000 7f7fffff 7f7fffff 7f7fffff 05
0108 02 0003 00000000 7f7fffff 7f7fffff 7f800000 05
0109 02 0003 00000000 ff7fffff ff7fffff ff7fffff 05
010a 02 0002 00000000 ff7fffff ff7fffff ff800000 05
010b 12 0000 00000000 00800001 00800000 00000000 03
010c 02 0004 00000000 3f800000 33800000 3f800001 01
010d 02 0000 00000000 3f800000 33800000 3f800000 01
010e 02 0003 00000000 3f800000 31000000 3f800001 01
010f 02 0002 00000000 3f800000 31000000 3f800000 01
0110 02 0000 00000000 bfc00000 3f000000 bf800000 00
0111 02 0000 00000000 7f800000 ff800000 7fc00000 10
0112 02 0000 00000000 3f800000 7f800000 7f800000 00
0201 03 0000 40000000 40400000 00000000 40c00000 00
0202 03 0000 3fc00000 3fc00000 00000000 40100000 00
0203 03 0000 3f800001 3f800001 00000000 3f800002 01
0204 03 0003 3f800001 3f800001 00000000 3f800003 01
0205 03 0001 3f800001 3f800001 00000000 3f800002 01
0206 03 0000 7f000000 40000000 00000000 7f800000 05
0207 03 0001 7f000000 40000000 00000000 7f7fffff 05
0208 03 0000 00800000 3f000000 00000000 00000000 03
0209 03 0000 80800000 3f000000 00000000 80000000 03
020a 03 0000 00000000 7f800000 00000000 7fc00000 10
020b 03 0000 c0000000 00000000 00000000 80000000 00
0301 07 0000 3f800000 40000000 00000000 3f800000 00
0302 07 0001 3f800000 c0000000 00000000 3f800000 00
0303 07 0000 00000000 80000000 00000000 80000000 00
0304 07 0001 80000000 00000000 00000000 00000000 00
0305 07 0000 7fc00000 3f800000 00000000 3f800000 00
0306 07 0001 7f800001 40000000 00000000 40000000 10
0307 07 0000 7fc00000 7fc00000 00000000 7fc00000 00
0308 06 0000 3f800000 c0000000 00000000 bf800000 00
0309 06 0001 3f800000 c0000000 00000000 3f800000 00
030a 06 0002 bf800000 c0000000 00000000 3f800000 00
030b 06 0000 ff800001 00000000 00000000 7f800001 00
0401 02 0000 00000000 40400000 3f800000 40800000 00
0402 03 0000 40800000 3e800000 00000000 3f800000 00
0403 01 0000 3f800000 3f800000 3f800000 7fc00000 10
0404 12 0000 00000000 40a00000 40400000 40000000 00

// File: dv/fpu_tb.sv
//--------------------
// Testbench for the FP32 unit with file-driven vectors and in-order result checks
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_VEC  = 64;
  localparam int VEC_COLS = 8;  // id, op, flags, op0, op1, op2, result, status
  localparam int GAP      = 3;  // Idle cycles between groups

  logic                                              clk;
  logic                                              rst_n;
  logic                                              fpu_req;
  logic [`FPU_NUM_OPERANDS-1:0][`FPU_DATA_WIDTH-1:0] fpu_operands;
  logic [`FPU_OP_WIDTH-1:0]                          fpu_op;
  logic [`FPU_IN_FLAGS_WIDTH-1:0]                    fpu_flags;
  logic                                              fpu_gnt;
  logic                                              fpu_valid;
  logic [`FPU_DATA_WIDTH-1:0]                        fpu_result;
  logic [`FPU_OUT_FLAGS_WIDTH-1:0]                   fpu_status;

  logic [31:0] vec_mem [0:MAX_VEC*VEC_COLS-1];
  logic [31:0] exp_res_q [$];
  logic [31:0] exp_flg_q [$];
  logic [31:0] id_q [$];
  int          due_q [$];
  int          cyc;
  int          limit;
  int          errors;
  int          checks;
  int          grp_errs;
  int          grp_checks;

  fpu_clk_gen clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fpu_wrap dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fpu_req_i      (fpu_req),
    .fpu_operands_i (fpu_operands),
    .fpu_op_i       (fpu_op),
    .fpu_flags_i    (fpu_flags),
    .fpu_gnt_o      (fpu_gnt),
    .fpu_valid_o    (fpu_valid),
    .fpu_result_o   (fpu_result),
    .fpu_flags_o    (fpu_status)
  );

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    grp_checks++;
    if (got !== expected) begin
      $display("Error: time %0t: %s got %h, expected %h", $time, what, got, expected);
      errors++;
      grp_errs++;
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //--------------------
  // Result monitor
  //--------------------
  always @(negedge clk) begin
    logic [31:0] id;
    if (due_q.size() != 0 && due_q[0] < cyc) begin
      $display("Test %h: no valid result in cycle %0d", id_q[0], due_q[0]);
      errors++;
      void'(due_q.pop_front());
      void'(exp_res_q.pop_front());
      void'(exp_flg_q.pop_front());
      void'(id_q.pop_front());
    end
    if (fpu_valid) begin
      if (due_q.size() == 0 || due_q[0] != cyc) begin
        $display("Valid result %h in cycle %0d where none was expected", fpu_result, cyc);
        errors++;
      end else begin
        id = id_q.pop_front();
        void'(due_q.pop_front());
        check_value($sformatf("test %h result", id), fpu_result, exp_res_q.pop_front());
        check_value($sformatf("test %h flags", id), 32'(fpu_status), exp_flg_q.pop_front());
        // Group done once the queue no longer holds the same group
        if (id_q.size() == 0 || (id_q[0] >> 8) != (id >> 8)) begin
          $display("Group %0d done: %0d checks, %0d errors", id >> 8, grp_checks, grp_errs);
          grp_checks = 0;
          grp_errs   = 0;
        end
      end
    end
  end

  //--------------------
  // Stimulus
  //--------------------
  initial begin
    int nvec;
    int ngroups;
    int base;
    limit        = 1000;
    errors       = 0;
    checks       = 0;
    grp_errs     = 0;
    grp_checks   = 0;
    fpu_req      = 1'b0;
    fpu_operands = '0;
    fpu_op       = '0;
    fpu_flags    = '0;
    for (int i = 0; i < MAX_VEC * VEC_COLS; i++) begin
      vec_mem[i] = {16'hffff, 16'(i)};  // End marker tagged with its address
    end
    $readmemh("dv/fpu_input.txt", vec_mem);
    nvec    = 0;
    ngroups = 0;
    while (nvec < MAX_VEC && vec_mem[nvec*VEC_COLS][31:16] != 16'hffff) begin
      if (nvec == 0 || (vec_mem[nvec*VEC_COLS] >> 8) != (vec_mem[(nvec-1)*VEC_COLS] >> 8)) begin
        ngroups++;
      end
      nvec++;
    end
    limit = 4 + nvec + GAP * ngroups + 20;
    if (nvec == 0) begin
      $display("No test vectors could be read from the input file");
      errors++;
    end

    // No grant and no valid while in reset
    repeat (2) begin
      @(negedge clk);
      check_value("grant in reset", 32'(fpu_gnt), 32'd0);
      check_value("valid in reset", 32'(fpu_valid), 32'd0);
    end
    @(negedge clk);
    check_value("grant after reset", 32'(fpu_gnt), 32'd1);
    check_value("valid after reset", 32'(fpu_valid), 32'd0);
    $display("Reset test done: %0d errors", errors);

    for (int v = 0; v < nvec; v++) begin
      base = v * VEC_COLS;
      if (v > 0 && (vec_mem[base] >> 8) != (vec_mem[base-VEC_COLS] >> 8)) begin
        fpu_req = 1'b0;
        repeat (GAP) @(negedge clk);
      end
      fpu_req      = 1'b1;
      fpu_op       = vec_mem[base+1][`FPU_OP_WIDTH-1:0];
      fpu_flags    = vec_mem[base+2][`FPU_IN_FLAGS_WIDTH-1:0];
      fpu_operands = {vec_mem[base+5], vec_mem[base+4], vec_mem[base+3]};
      id_q.push_back(vec_mem[base]);
      exp_res_q.push_back(vec_mem[base+6]);
      exp_flg_q.push_back(vec_mem[base+7]);
      due_q.push_back(cyc + 2);  // Result register loads one edge after the accepting edge
      @(negedge clk);
    end
    fpu_req = 1'b0;
    while (due_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);  // Catch stray valids

    $display("Checked %0d values over %0d vectors, %0d errors", checks, nvec, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Cycle limit
  initial begin
    @(posedge clk);
    while (cyc < limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: fpu_core/fpu_addsub.sv
//--------------------
// FP32 add/subtract up to normalization, rounding is left to the result stage
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_addsub (
  input  wire logic [`FPU_DATA_WIDTH-1:0] operand_a_i,
  input  wire logic [`FPU_DATA_WIDTH-1:0] operand_b_i,
  input  wire fpu_pkg::fp_class_e         class_a_i,
  input  wire fpu_pkg::fp_class_e         class_b_i,
  input  wire logic                       sub_i,
  output logic                            sign_o,
  output logic signed [9:0]               exp_o,
  output logic [23:0]                     mant_o,
  output logic                            guard_o,
  output logic                            sticky_o,
  output logic                            special_o,
  output logic [`FPU_DATA_WIDTH-1:0]      special_value_o,
  output logic                            invalid_o
);

  logic        sign_a;
  logic        sign_b;
  logic [30:0] mag_a;
  logic [30:0] mag_b;
  logic        a_big;
  logic [30:0] mag_l;
  logic [30:0] mag_s;
  logic        sign_l;
  logic        sign_s;
  logic [23:0] man_l;
  logic [23:0] man_s;
  logic [7:0]  exp_diff;
  logic [4:0]  shamt;
  logic [53:0] shifted;
  logic [26:0] aligned;
  logic [27:0] sum;
  logic [4:0]  lzc;
  logic [27:0] norm;
  logic        any_nan;
  logic        any_snan;
  logic        a_inf;
  logic        b_inf;

  assign sign_a = operand_a_i[31];
  assign sign_b = operand_b_i[31] ^ sub_i;  // Effective sign of b
  assign mag_a  = (class_a_i == fpu_pkg::NORMAL) ? operand_a_i[30:0] : '0;
  assign mag_b  = (class_b_i == fpu_pkg::NORMAL) ? operand_b_i[30:0] : '0;

  //--------------------
  // Swap and align
  //--------------------
  assign a_big  = mag_a >= mag_b;
  assign mag_l  = a_big ? mag_a : mag_b;
  assign mag_s  = a_big ? mag_b : mag_a;
  assign sign_l = a_big ? sign_a : sign_b;
  assign sign_s = a_big ? sign_b : sign_a;
  assign man_l  = {mag_l != 31'd0, mag_l[22:0]};  // Hidden bit only when nonzero
  assign man_s  = {mag_s != 31'd0, mag_s[22:0]};

  assign exp_diff = mag_l[30:23] - mag_s[30:23];
  assign shamt    = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
  assign shifted  = {man_s, 3'b000, 27'd0} >> shamt;
  // Shifted-out bits collapse into the sticky position
  assign aligned  = {shifted[53:28], shifted[27] | (|shifted[26:0])};

  assign sum = (sign_l ^ sign_s) ? {1'b0, man_l, 3'b000} - {1'b0, aligned}
                                 : {1'b0, man_l, 3'b000} + {1'b0, aligned};

  //--------------------
  // Normalize
  //--------------------
  always_comb begin
    lzc = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (sum[i]) begin
        lzc = 5'(27 - i);  // Highest set bit wins
      end
    end
  end

  assign norm     = sum << lzc;
  assign exp_o    = $signed({2'b00, mag_l[30:23]}) + 10'sd1 - $signed({5'd0, lzc});
  assign mant_o   = norm[27:4];
  assign guard_o  = norm[3];
  assign sticky_o = |norm[2:0];

  assign any_snan = (class_a_i == fpu_pkg::SNAN) | (class_b_i == fpu_pkg::SNAN);
  assign any_nan  = any_snan | (class_a_i == fpu_pkg::QNAN) | (class_b_i == fpu_pkg::QNAN);
  assign a_inf    = class_a_i == fpu_pkg::INF;
  assign b_inf    = class_b_i == fpu_pkg::INF;

  always_comb begin
    special_o       = 1'b1;
    special_value_o = fpu_pkg::CANON_NAN;
    invalid_o       = any_snan;
    sign_o          = sign_l;
    if (any_nan) begin
      special_value_o = fpu_pkg::CANON_NAN;
    end else if (a_inf && b_inf && (sign_a != sign_b)) begin
      invalid_o = 1'b1;  // inf - inf
    end else if (a_inf) begin
      special_value_o = {sign_a, 8'hff, 23'd0};
    end else if (b_inf) begin
      special_value_o = {sign_b, 8'hff, 23'd0};
    end else if (sum == 28'd0) begin
      // Exact zero, sign_o carries the round-down sign
      special_value_o = {sign_a & sign_b, 31'd0};
      sign_o          = sign_a | sign_b;
    end else begin
      special_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: fpu_core/fpu_mul.sv
//--------------------
// FP32 multiply up to normalization, unrounded
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_mul (
  input  wire logic [`FPU_DATA_WIDTH-1:0] operand_a_i,
  input  wire logic [`FPU_DATA_WIDTH-1:0] operand_b_i,
  input  wire fpu_pkg::fp_class_e         class_a_i,
  input  wire fpu_pkg::fp_class_e         class_b_i,
  output logic                            sign_o,
  output logic signed [9:0]               exp_o,
  output logic [23:0]                     mant_o,
  output logic                            guard_o,
  output logic                            sticky_o,
  output logic                            special_o,
  output logic [`FPU_DATA_WIDTH-1:0]      special_value_o,
  output logic                            invalid_o
);

  logic [47:0]       prod;
  logic signed [9:0] exp_sum;
  logic              any_nan;
  logic              any_snan;
  logic              a_inf;
  logic              b_inf;
  logic              a_zero;
  logic              b_zero;

  assign sign_o  = operand_a_i[31] ^ operand_b_i[31];
  assign prod    = {1'b1, operand_a_i[22:0]} * {1'b1, operand_b_i[22:0]};
  assign exp_sum = $signed({2'b00, operand_a_i[30:23]})
                 + $signed({2'b00, operand_b_i[30:23]}) - 10'sd127;

  // Product lies in [1, 4), so at most one right shift
  always_comb begin
    if (prod[47]) begin
      exp_o    = exp_sum + 10'sd1;
      mant_o   = prod[47:24];
      guard_o  = prod[23];
      sticky_o = |prod[22:0];
    end else begin
      exp_o    = exp_sum;
      mant_o   = prod[46:23];
      guard_o  = prod[22];
      sticky_o = |prod[21:0];
    end
  end

  assign any_snan = (class_a_i == fpu_pkg::SNAN) | (class_b_i == fpu_pkg::SNAN);
  assign any_nan  = any_snan | (class_a_i == fpu_pkg::QNAN) | (class_b_i == fpu_pkg::QNAN);
  assign a_inf    = class_a_i == fpu_pkg::INF;
  assign b_inf    = class_b_i == fpu_pkg::INF;
  assign a_zero   = class_a_i == fpu_pkg::ZERO;
  assign b_zero   = class_b_i == fpu_pkg::ZERO;

  always_comb begin
    special_o       = 1'b1;
    special_value_o = fpu_pkg::CANON_NAN;
    invalid_o       = any_snan;
    if (any_nan) begin
      special_value_o = fpu_pkg::CANON_NAN;
    end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
      invalid_o = 1'b1;
    end else if (a_inf || b_inf) begin
      special_value_o = {sign_o, 8'hff, 23'd0};
    end else if (a_zero || b_zero) begin
      special_value_o = {sign_o, 31'd0};
    end else begin
      special_o = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: fpu_core/fpu_noncomp.sv
//--------------------
// Min/max and sign injection
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_noncomp (
  input  wire logic [`FPU_DATA_WIDTH-1:0] operand_a_i,
  input  wire logic [`FPU_DATA_WIDTH-1:0] operand_b_i,
  input  wire fpu_pkg::fp_class_e         class_a_i,
  input  wire fpu_pkg::fp_class_e         class_b_i,
  input  wire fpu_pkg::round_mode_e       rnd_mode_i,
  output logic [1:0][`FPU_DATA_WIDTH-1:0] result_o,  // [0] min/max, [1] sign injection
  output logic                            invalid_o
);

  logic a_nan;
  logic b_nan;
  logic a_lt_b;
  logic [`FPU_DATA_WIDTH-1:0] lo;
  logic [`FPU_DATA_WIDTH-1:0] hi;

  assign a_nan = (class_a_i == fpu_pkg::QNAN) | (class_a_i == fpu_pkg::SNAN);
  assign b_nan = (class_b_i == fpu_pkg::QNAN) | (class_b_i == fpu_pkg::SNAN);
  assign invalid_o = (class_a_i == fpu_pkg::SNAN) | (class_b_i == fpu_pkg::SNAN);

  // Sign-magnitude compare, so -0 orders below +0
  assign a_lt_b = (operand_a_i[31] != operand_b_i[31]) ? operand_a_i[31] :
                  operand_a_i[31] ? (operand_a_i[30:0] > operand_b_i[30:0])
                                  : (operand_a_i[30:0] < operand_b_i[30:0]);
  assign lo = a_lt_b ? operand_a_i : operand_b_i;
  assign hi = a_lt_b ? operand_b_i : operand_a_i;

  always_comb begin
    if (a_nan && b_nan) begin
      result_o[0] = fpu_pkg::CANON_NAN;
    end else if (a_nan) begin
      result_o[0] = operand_b_i;
    end else if (b_nan) begin
      result_o[0] = operand_a_i;
    end else begin
      result_o[0] = (rnd_mode_i == fpu_pkg::RTZ) ? hi : lo;
    end
    case (rnd_mode_i)
      fpu_pkg::RTZ: result_o[1] = {~operand_b_i[31], operand_a_i[30:0]};
      fpu_pkg::RDN: result_o[1] = {operand_a_i[31] ^ operand_b_i[31], operand_a_i[30:0]};
      default:      result_o[1] = {operand_b_i[31], operand_a_i[30:0]};
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/fpu_req_stage.sv
//--------------------
// Request stage: grant, request capture, operand select and classify
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_req_stage (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_n_i,
  input  wire logic                                             req_i,
  input  wire logic [`FPU_NUM_OPERANDS-1:0][`FPU_DATA_WIDTH-1:0] operands_i,
  input  wire logic [`FPU_OP_WIDTH-1:0]                         op_i,
  input  wire logic [`FPU_IN_FLAGS_WIDTH-1:0]                   flags_i,
  output logic                                                  gnt_o,
  output logic                                                  valid_o,
  output fpu_pkg::fp_op_e                                       op_o,
  output logic                                                  op_mod_o,
  output fpu_pkg::round_mode_e                                  rnd_mode_o,
  output logic [`FPU_DATA_WIDTH-1:0]                            operand_a_o,
  output logic [`FPU_DATA_WIDTH-1:0]                            operand_b_o,
  output fpu_pkg::fp_class_e                                    class_a_o,
  output fpu_pkg::fp_class_e                                    class_b_o
);

  logic                        gnt_q;
  logic                        valid_q;
  logic                        accept;
  fpu_pkg::fp_op_e             op_in;
  fpu_pkg::fp_op_e             op_q;
  logic                        mod_q;
  fpu_pkg::round_mode_e        rnd_q;
  logic [`FPU_DATA_WIDTH-1:0]  opa_q;
  logic [`FPU_DATA_WIDTH-1:0]  opb_q;

  function automatic fpu_pkg::fp_class_e classify(input logic [`FPU_DATA_WIDTH-1:0] v);
    if (v[30:23] == 8'h00) begin
      return fpu_pkg::ZERO;  // Subnormals flushed
    end else if (v[30:23] != 8'hff) begin
      return fpu_pkg::NORMAL;
    end else if (v[22:0] == 23'd0) begin
      return fpu_pkg::INF;
    end
    return v[22] ? fpu_pkg::QNAN : fpu_pkg::SNAN;
  endfunction

  assign accept = req_i & gnt_q;
  assign op_in  = fpu_pkg::fp_op_e'(op_i[3:0]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      gnt_q   <= 1'b1;  // No back-pressure once out of reset
      valid_q <= accept;
    end
  end

  // Add takes operands 1 and 2, the rest take 0 and 1
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= op_in;
      mod_q <= op_i[`FPU_OP_WIDTH-2];
      rnd_q <= fpu_pkg::round_mode_e'(flags_i[2:0]);
      opa_q <= (op_in == fpu_pkg::FP_ADD) ? operands_i[1] : operands_i[0];
      opb_q <= (op_in == fpu_pkg::FP_ADD) ? operands_i[2] : operands_i[1];
    end
  end

  assign gnt_o       = gnt_q;
  assign valid_o     = valid_q;
  assign op_o        = op_q;
  assign op_mod_o    = mod_q;
  assign rnd_mode_o  = rnd_q;
  assign operand_a_o = opa_q;
  assign operand_b_o = opb_q;
  assign class_a_o   = classify(opa_q);
  assign class_b_o   = classify(opb_q);

endmodule

`default_nettype wire

// File: rtl/fpu_result_stage.sv
//--------------------
// Result stage: unit select, rounding, range checks, output register
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_result_stage (
  input  wire logic                             clk_i,
  input  wire logic                             rst_n_i,
  input  wire logic                             valid_i,
  input  wire fpu_pkg::fp_op_e                  op_i,
  input  wire fpu_pkg::round_mode_e             rnd_mode_i,
  input  wire logic                             add_sign_i,
  input  wire logic signed [9:0]                add_exp_i,
  input  wire logic [23:0]                      add_mant_i,
  input  wire logic                             add_guard_i,
  input  wire logic                             add_sticky_i,
  input  wire logic                             add_special_i,
  input  wire logic [`FPU_DATA_WIDTH-1:0]       add_special_value_i,
  input  wire logic                             add_invalid_i,
  input  wire logic                             mul_sign_i,
  input  wire logic signed [9:0]                mul_exp_i,
  input  wire logic [23:0]                      mul_mant_i,
  input  wire logic                             mul_guard_i,
  input  wire logic                             mul_sticky_i,
  input  wire logic                             mul_special_i,
  input  wire logic [`FPU_DATA_WIDTH-1:0]       mul_special_value_i,
  input  wire logic                             mul_invalid_i,
  input  wire logic [1:0][`FPU_DATA_WIDTH-1:0]  nc_result_i,
  input  wire logic                             nc_invalid_i,
  output logic                                  valid_o,
  output logic [`FPU_DATA_WIDTH-1:0]            result_o,
  output logic [`FPU_OUT_FLAGS_WIDTH-1:0]       flags_o
);

  logic                             is_add;
  logic                             sign;
  logic signed [9:0]                exp_n;
  logic signed [9:0]                exp_r;
  logic [23:0]                      mant;
  logic                             guard;
  logic                             sticky;
  logic                             special;
  logic [`FPU_DATA_WIDTH-1:0]       special_value;
  logic                             invalid;
  logic                             inexact;
  logic                             round_up;
  logic [24:0]                      mant_r;
  logic                             to_max;
  logic [`FPU_DATA_WIDTH-1:0]       result_d;
  logic [`FPU_OUT_FLAGS_WIDTH-1:0]  flags_d;
  logic                             valid_q;
  logic [`FPU_DATA_WIDTH-1:0]       result_q;
  logic [`FPU_OUT_FLAGS_WIDTH-1:0]  flags_q;

  assign is_add        = op_i == fpu_pkg::FP_ADD;
  assign sign          = is_add ? add_sign_i : mul_sign_i;
  assign exp_n         = is_add ? add_exp_i : mul_exp_i;
  assign mant          = is_add ? add_mant_i : mul_mant_i;
  assign guard         = is_add ? add_guard_i : mul_guard_i;
  assign sticky        = is_add ? add_sticky_i : mul_sticky_i;
  assign special       = is_add ? add_special_i : mul_special_i;
  assign special_value = is_add ? add_special_value_i : mul_special_value_i;
  assign invalid       = is_add ? add_invalid_i : mul_invalid_i;

  //--------------------
  // Rounding
  //--------------------
  assign inexact = guard | sticky;

  always_comb begin
    case (rnd_mode_i)
      fpu_pkg::RTZ: round_up = 1'b0;
      fpu_pkg::RDN: round_up = sign & inexact;
      fpu_pkg::RUP: round_up = ~sign & inexact;
      fpu_pkg::RMM: round_up = guard;
      default:      round_up = guard & (sticky | mant[0]);  // Ties to even
    endcase
  end

  assign mant_r = {1'b0, mant} + {24'd0, round_up};
  assign exp_r  = mant_r[24] ? exp_n + 10'sd1 : exp_n;  // Carry-out leaves fraction zero
  assign to_max = (rnd_mode_i == fpu_pkg::RTZ) | ((rnd_mode_i == fpu_pkg::RDN) & ~sign) |
                  ((rnd_mode_i == fpu_pkg::RUP) & sign);

  always_comb begin
    case (op_i)
      fpu_pkg::FP_ADD, fpu_pkg::FP_MUL: begin
        if (special) begin
          result_d = special_value;
          flags_d  = {invalid, 4'b0000};
          // Zero sum rounding down takes the OR of the signs
          if (is_add && (special_value[30:0] == 31'd0) && (rnd_mode_i == fpu_pkg::RDN)) begin
            result_d = {sign, 31'd0};
          end
        end else if (exp_r >= 10'sd255) begin
          result_d = to_max ? {sign, 8'hfe, 23'h7fffff} : {sign, 8'hff, 23'd0};
          flags_d  = 5'b00101;  // OF, NX
        end else if (exp_r <= 10'sd0) begin
          result_d = {sign, 31'd0};
          flags_d  = 5'b00011;  // UF, NX
        end else begin
          result_d = {sign, exp_r[7:0], mant_r[22:0]};
          flags_d  = {4'b0000, inexact};
        end
      end
      fpu_pkg::FP_MINMAX: begin
        result_d = nc_result_i[0];
        flags_d  = {nc_invalid_i, 4'b0000};
      end
      fpu_pkg::FP_SGNJ: begin
        result_d = nc_result_i[1];
        flags_d  = '0;
      end
      default: begin
        result_d = fpu_pkg::CANON_NAN;
        flags_d  = 5'b10000;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_q <= result_d;
      flags_q  <= flags_d;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign flags_o  = flags_q;

endmodule

`default_nettype wire

// File: rtl/fpu_wrap.sv
//--------------------
// FP32 unit top: request stage, core units, result stage
//--------------------
`default_nettype none
`include "fpu_macros.svh"

module fpu_wrap (
  input  wire logic                                              clk_i,
  input  wire logic                                              rst_n_i,
  input  wire logic                                              fpu_req_i,
  input  wire logic [`FPU_NUM_OPERANDS-1:0][`FPU_DATA_WIDTH-1:0] fpu_operands_i,
  input  wire logic [`FPU_OP_WIDTH-1:0]                          fpu_op_i,
  input  wire logic [`FPU_IN_FLAGS_WIDTH-1:0]                    fpu_flags_i,
  output logic                                                   fpu_gnt_o,
  output logic                                                   fpu_valid_o,
  output logic [`FPU_DATA_WIDTH-1:0]                             fpu_result_o,
  output logic [`FPU_OUT_FLAGS_WIDTH-1:0]                        fpu_flags_o
);

  logic                             req_valid;
  fpu_pkg::fp_op_e                  op;
  logic                             op_mod;
  fpu_pkg::round_mode_e             rnd_mode;
  logic [`FPU_DATA_WIDTH-1:0]       opa;
  logic [`FPU_DATA_WIDTH-1:0]       opb;
  fpu_pkg::fp_class_e               cls_a;
  fpu_pkg::fp_class_e               cls_b;
  logic                             add_sign;
  logic signed [9:0]                add_exp;
  logic [23:0]                      add_mant;
  logic                             add_guard;
  logic                             add_sticky;
  logic                             add_special;
  logic [`FPU_DATA_WIDTH-1:0]       add_special_value;
  logic                             add_invalid;
  logic                             mul_sign;
  logic signed [9:0]                mul_exp;
  logic [23:0]                      mul_mant;
  logic                             mul_guard;
  logic                             mul_sticky;
  logic                             mul_special;
  logic [`FPU_DATA_WIDTH-1:0]       mul_special_value;
  logic                             mul_invalid;
  logic [1:0][`FPU_DATA_WIDTH-1:0]  nc_result;
  logic                             nc_invalid;

  fpu_req_stage i_req (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (fpu_req_i),
    .operands_i  (fpu_operands_i),
    .op_i        (fpu_op_i),
    .flags_i     (fpu_flags_i),
    .gnt_o       (fpu_gnt_o),
    .valid_o     (req_valid),
    .op_o        (op),
    .op_mod_o    (op_mod),
    .rnd_mode_o  (rnd_mode),
    .operand_a_o (opa),
    .operand_b_o (opb),
    .class_a_o   (cls_a),
    .class_b_o   (cls_b)
  );

  fpu_addsub i_addsub (
    .operand_a_i     (opa),
    .operand_b_i     (opb),
    .class_a_i       (cls_a),
    .class_b_i       (cls_b),
    .sub_i           (op_mod),
    .sign_o          (add_sign),
    .exp_o           (add_exp),
    .mant_o          (add_mant),
    .guard_o         (add_guard),
    .sticky_o        (add_sticky),
    .special_o       (add_special),
    .special_value_o (add_special_value),
    .invalid_o       (add_invalid)
  );

  fpu_mul i_mul (
    .operand_a_i     (opa),
    .operand_b_i     (opb),
    .class_a_i       (cls_a),
    .class_b_i       (cls_b),
    .sign_o          (mul_sign),
    .exp_o           (mul_exp),
    .mant_o          (mul_mant),
    .guard_o         (mul_guard),
    .sticky_o        (mul_sticky),
    .special_o       (mul_special),
    .special_value_o (mul_special_value),
    .invalid_o       (mul_invalid)
  );

  fpu_noncomp i_noncomp (
    .operand_a_i (opa),
    .operand_b_i (opb),
    .class_a_i   (cls_a),
    .class_b_i   (cls_b),
    .rnd_mode_i  (rnd_mode),
    .result_o    (nc_result),
    .invalid_o   (nc_invalid)
  );

  fpu_result_stage i_result (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .valid_i             (req_valid),
    .op_i                (op),
    .rnd_mode_i          (rnd_mode),
    .add_sign_i          (add_sign),
    .add_exp_i           (add_exp),
    .add_mant_i          (add_mant),
    .add_guard_i         (add_guard),
    .add_sticky_i        (add_sticky),
    .add_special_i       (add_special),
    .add_special_value_i (add_special_value),
    .add_invalid_i       (add_invalid),
    .mul_sign_i          (mul_sign),
    .mul_exp_i           (mul_exp),
    .mul_mant_i          (mul_mant),
    .mul_guard_i         (mul_guard),
    .mul_sticky_i        (mul_sticky),
    .mul_special_i       (mul_special),
    .mul_special_value_i (mul_special_value),
    .mul_invalid_i       (mul_invalid),
    .nc_result_i         (nc_result),
    .nc_invalid_i        (nc_invalid),
    .valid_o             (fpu_valid_o),
    .result_o            (fpu_result_o),
    .flags_o             (fpu_flags_o)
  );

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/fpu_pkg.sv
rtl/fpu_req_stage.sv
fpu_core/fpu_addsub.sv
fpu_core/fpu_mul.sv
fpu_core/fpu_noncomp.sv
rtl/fpu_result_stage.sv
rtl/fpu_wrap.sv
dv/fpu_clk_gen.sv
dv/fpu_tb.sv
